// ==== source/mem_pkg.sv ====
// Memory widths and encodings; MEM_BYTES must be a power of two and data is 64 bits wide
package mem_pkg;

    // ----------------------------------------
    // Widths and memory size
    // ----------------------------------------
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 64;
    localparam int TAG_W      = 4;
    localparam int DATA_BYTES = DATA_W / 8;
    localparam int MEM_BYTES  = 256;
    localparam int MEM_AW     = $clog2(MEM_BYTES);

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [TAG_W-1:0]  tag_t;
    // Byte index inside the array
    typedef logic [MEM_AW-1:0] idx_t;

    // ----------------------------------------
    // Request encodings
    // ----------------------------------------
    typedef logic [1:0] acc_type_t;
    localparam acc_type_t ACC_INSTR = 2'd0;
    localparam acc_type_t ACC_LD    = 2'd1;
    localparam acc_type_t ACC_ST    = 2'd2;

    typedef logic [2:0] ls_type_t;
    localparam ls_type_t LS_BYTE   = 3'd0;
    localparam ls_type_t LS_BYTE_U = 3'd1;
    localparam ls_type_t LS_HALF   = 3'd2;
    localparam ls_type_t LS_HALF_U = 3'd3;
    localparam ls_type_t LS_WORD   = 3'd4;
    localparam ls_type_t LS_WORD_U = 3'd5;
    localparam ls_type_t LS_DWORD  = 3'd6;

    // Log2 of the access size in bytes
    typedef logic [1:0] size_t;

endpackage

// ==== source/except_pkg.sv ====
// Exception codes follow the RISC-V mcause numbering, memory faults only
package except_pkg;

    typedef logic [3:0] except_code_t;

    // Instruction fetch
    localparam except_code_t E_I_ADDR_MISALIGNED  = 4'd0;
    localparam except_code_t E_I_ACCESS_FAULT     = 4'd1;

    // Loads
    localparam except_code_t E_LD_ADDR_MISALIGNED = 4'd4;
    localparam except_code_t E_LD_ACCESS_FAULT    = 4'd5;

    // Stores
    localparam except_code_t E_ST_ADDR_MISALIGNED = 4'd6;
    localparam except_code_t E_ST_ACCESS_FAULT    = 4'd7;

    // Also sent when no exception is raised
    localparam except_code_t E_UNKNOWN            = 4'd15;

endpackage

// ==== source/mem_req_check.sv ====
// Purely combinational; misalignment wins over range faults and fetches are word reads
`timescale 1ns/10ps

module mem_req_check (
    input  mem_pkg::acc_type_t       req_acc_type_i,
    input  mem_pkg::ls_type_t        req_ls_type_i,
    input  mem_pkg::addr_t           req_addr_i,
    output mem_pkg::size_t           size_o,
    output logic                     signed_o,
    output logic                     access_ok_o,
    output logic                     except_o,
    output except_pkg::except_code_t except_code_o
);

    logic [3:0]               nbytes;
    logic [2:0]               align_mask;
    logic [mem_pkg::ADDR_W:0] end_addr;
    logic                     misaligned;
    logic                     out_of_range;

    // ----------------------------------------
    // Size and sign decode
    // ----------------------------------------
    always_comb begin
        size_o = 2'd2;
        if (req_acc_type_i != mem_pkg::ACC_INSTR) begin
            case (req_ls_type_i)
                mem_pkg::LS_BYTE, mem_pkg::LS_BYTE_U: size_o = 2'd0;
                mem_pkg::LS_HALF, mem_pkg::LS_HALF_U: size_o = 2'd1;
                mem_pkg::LS_WORD, mem_pkg::LS_WORD_U: size_o = 2'd2;
                default:                              size_o = 2'd3;
            endcase
        end
    end

    // Only loads sign-extend
    assign signed_o = (req_acc_type_i == mem_pkg::ACC_LD) &&
                      (req_ls_type_i inside {mem_pkg::LS_BYTE, mem_pkg::LS_HALF,
                                             mem_pkg::LS_WORD});

    // ----------------------------------------
    // Fault detection
    // ----------------------------------------
    assign nbytes     = 4'd1 << size_o;
    assign align_mask = 3'(nbytes - 4'd1);
    assign misaligned = |(req_addr_i[2:0] & align_mask);

    // One past the last byte touched, with a carry bit for addresses near the top
    assign end_addr     = {1'b0, req_addr_i} + {{(mem_pkg::ADDR_W-3){1'b0}}, nbytes};
    assign out_of_range = end_addr > (mem_pkg::ADDR_W+1)'(mem_pkg::MEM_BYTES);

    assign except_o    = misaligned || out_of_range;
    assign access_ok_o = !except_o;

    always_comb begin
        except_code_o = except_pkg::E_UNKNOWN;
        if (misaligned) begin
            case (req_acc_type_i)
                mem_pkg::ACC_INSTR: except_code_o = except_pkg::E_I_ADDR_MISALIGNED;
                mem_pkg::ACC_LD:    except_code_o = except_pkg::E_LD_ADDR_MISALIGNED;
                mem_pkg::ACC_ST:    except_code_o = except_pkg::E_ST_ADDR_MISALIGNED;
                default:            except_code_o = except_pkg::E_UNKNOWN;
            endcase
        end else if (out_of_range) begin
            case (req_acc_type_i)
                mem_pkg::ACC_INSTR: except_code_o = except_pkg::E_I_ACCESS_FAULT;
                mem_pkg::ACC_LD:    except_code_o = except_pkg::E_LD_ACCESS_FAULT;
                mem_pkg::ACC_ST:    except_code_o = except_pkg::E_ST_ACCESS_FAULT;
                default:            except_code_o = except_pkg::E_UNKNOWN;
            endcase
        end
    end

endmodule

// ==== source/mem_byte_array.sv ====
// Array contents are undefined until written; out-of-range reads return zero
`timescale 1ns/10ps

module mem_byte_array (
    input  logic           clk_i,
    input  logic           wr_en_i,
    input  mem_pkg::addr_t addr_i,
    input  mem_pkg::size_t size_i,
    input  logic           signed_i,
    input  mem_pkg::data_t wdata_i,
    output mem_pkg::data_t rdata_o
);

    logic [7:0]     mem_q [mem_pkg::MEM_BYTES];
    mem_pkg::idx_t  base_idx;
    logic           in_range;
    logic [3:0]     nbytes;
    mem_pkg::data_t raw;

    assign base_idx = addr_i[mem_pkg::MEM_AW-1:0];
    assign in_range = (addr_i[mem_pkg::ADDR_W-1:mem_pkg::MEM_AW] == '0);
    assign nbytes   = 4'd1 << size_i;

    // ----------------------------------------
    // Sized write, little-endian
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (wr_en_i && in_range) begin
            for (int b = 0; b < mem_pkg::DATA_BYTES; b++) begin
                if (b < int'(nbytes)) begin
                    mem_q[base_idx + mem_pkg::idx_t'(b)] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // ----------------------------------------
    // Read and extend
    // ----------------------------------------
    // Gather a full doubleword starting at the base byte
    always_comb begin
        for (int b = 0; b < mem_pkg::DATA_BYTES; b++) begin
            raw[8*b +: 8] = mem_q[base_idx + mem_pkg::idx_t'(b)];
        end
    end

    // Keep the low bytes and fill the rest by sign or zero
    always_comb begin
        rdata_o = '0;
        if (in_range) begin
            case (size_i)
                2'd0: begin
                    rdata_o = {{(mem_pkg::DATA_W-8){signed_i & raw[7]}}, raw[7:0]};
                end
                2'd1: begin
                    rdata_o = {{(mem_pkg::DATA_W-16){signed_i & raw[15]}}, raw[15:0]};
                end
                2'd2: begin
                    rdata_o = {{(mem_pkg::DATA_W-32){signed_i & raw[31]}}, raw[31:0]};
                end
                default: begin
                    rdata_o = raw;
                end
            endcase
        end
    end

endmodule

// ==== source/mem_ans_buffer.sv ====
// Two-entry spill buffer; ready_o is registered and answers accepted during a flush are lost
`timescale 1ns/10ps

module mem_ans_buffer (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     flush_i,
    input  logic                     valid_i,
    input  logic                     ready_i,
    input  mem_pkg::tag_t            in_tag_i,
    input  mem_pkg::acc_type_t       in_acc_type_i,
    input  mem_pkg::addr_t           in_addr_i,
    input  mem_pkg::data_t           in_value_i,
    input  logic                     in_except_i,
    input  except_pkg::except_code_t in_except_code_i,
    output logic                     valid_o,
    output logic                     ready_o,
    output mem_pkg::tag_t            out_tag_o,
    output mem_pkg::acc_type_t       out_acc_type_o,
    output mem_pkg::addr_t           out_addr_o,
    output mem_pkg::data_t           out_value_o,
    output logic                     out_except_o,
    output except_pkg::except_code_t out_except_code_o
);

    logic                     main_valid_q;
    logic                     spill_valid_q;
    logic                     accept;
    logic                     take;
    logic                     main_load;
    logic                     spill_load;

    mem_pkg::tag_t            spill_tag_q;
    mem_pkg::acc_type_t       spill_acc_type_q;
    mem_pkg::addr_t           spill_addr_q;
    mem_pkg::data_t           spill_value_q;
    logic                     spill_except_q;
    except_pkg::except_code_t spill_except_code_q;

    assign ready_o = !spill_valid_q;
    assign valid_o = main_valid_q;
    assign accept  = valid_i && ready_o;
    assign take    = main_valid_q && ready_i;

    // Main entry refills whenever it is empty or being drained
    assign main_load  = !main_valid_q || take;
    // Spill catches an answer only when main is held
    assign spill_load = accept && main_valid_q && !take;

    // ----------------------------------------
    // Valid flags
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            main_valid_q  <= 1'b0;
            spill_valid_q <= 1'b0;
        end else if (flush_i) begin
            main_valid_q  <= 1'b0;
            spill_valid_q <= 1'b0;
        end else begin
            if (main_load) begin
                main_valid_q <= spill_valid_q || accept;
            end
            if (spill_valid_q && take) begin
                spill_valid_q <= 1'b0;
            end else if (spill_load) begin
                spill_valid_q <= 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Payload registers
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (main_load) begin
            // Older answer in the spill entry goes out first
            if (spill_valid_q) begin
                out_tag_o         <= spill_tag_q;
                out_acc_type_o    <= spill_acc_type_q;
                out_addr_o        <= spill_addr_q;
                out_value_o       <= spill_value_q;
                out_except_o      <= spill_except_q;
                out_except_code_o <= spill_except_code_q;
            end else begin
                out_tag_o         <= in_tag_i;
                out_acc_type_o    <= in_acc_type_i;
                out_addr_o        <= in_addr_i;
                out_value_o       <= in_value_i;
                out_except_o      <= in_except_i;
                out_except_code_o <= in_except_code_i;
            end
        end
        if (spill_load) begin
            spill_tag_q         <= in_tag_i;
            spill_acc_type_q    <= in_acc_type_i;
            spill_addr_q        <= in_addr_i;
            spill_value_q       <= in_value_i;
            spill_except_q      <= in_except_i;
            spill_except_code_q <= in_except_code_i;
        end
    end

endmodule

// ==== source/mem_emu_top.sv ====
// One request per cycle with no wait states; stores commit on the accepting edge
`timescale 1ns/10ps

module mem_emu_top (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     flush_i,
    input  logic                     valid_i,
    input  logic                     ready_i,
    input  mem_pkg::tag_t            req_tag_i,
    input  mem_pkg::acc_type_t       req_acc_type_i,
    input  mem_pkg::ls_type_t        req_ls_type_i,
    input  mem_pkg::addr_t           req_addr_i,
    input  mem_pkg::data_t           req_value_i,
    output logic                     ready_o,
    output logic                     valid_o,
    output mem_pkg::tag_t            ans_tag_o,
    output mem_pkg::acc_type_t       ans_acc_type_o,
    output mem_pkg::addr_t           ans_addr_o,
    output mem_pkg::data_t           ans_value_o,
    output logic                     ans_except_o,
    output except_pkg::except_code_t ans_except_code_o
);

    mem_pkg::size_t           size;
    logic                     signed_rd;
    logic                     access_ok;
    logic                     except;
    except_pkg::except_code_t except_code;
    mem_pkg::data_t           rdata;
    logic                     wr_en;
    mem_pkg::data_t           ans_value;

    mem_req_check u_req_check (
        .req_acc_type_i (req_acc_type_i),
        .req_ls_type_i  (req_ls_type_i),
        .req_addr_i     (req_addr_i),
        .size_o         (size),
        .signed_o       (signed_rd),
        .access_ok_o    (access_ok),
        .except_o       (except),
        .except_code_o  (except_code)
    );

    // Only accepted, fault-free stores touch the array
    assign wr_en = valid_i && ready_o && access_ok && (req_acc_type_i == mem_pkg::ACC_ST);

    mem_byte_array u_byte_array (
        .clk_i    (clk_i),
        .wr_en_i  (wr_en),
        .addr_i   (req_addr_i),
        .size_i   (size),
        .signed_i (signed_rd),
        .wdata_i  (req_value_i),
        .rdata_o  (rdata)
    );

    // Stores and faulting requests carry no data back
    assign ans_value = (except || (req_acc_type_i == mem_pkg::ACC_ST)) ? '0 : rdata;

    mem_ans_buffer u_ans_buffer (
        .clk_i             (clk_i),
        .arst_n_i          (arst_n_i),
        .flush_i           (flush_i),
        .valid_i           (valid_i),
        .ready_i           (ready_i),
        .in_tag_i          (req_tag_i),
        .in_acc_type_i     (req_acc_type_i),
        .in_addr_i         (req_addr_i),
        .in_value_i        (ans_value),
        .in_except_i       (except),
        .in_except_code_i  (except_code),
        .valid_o           (valid_o),
        .ready_o           (ready_o),
        .out_tag_o         (ans_tag_o),
        .out_acc_type_o    (ans_acc_type_o),
        .out_addr_o        (ans_addr_o),
        .out_value_o       (ans_value_o),
        .out_except_o      (ans_except_o),
        .out_except_code_o (ans_except_code_o)
    );

endmodule

// ==== tests/mem_emu_checker.sv ====
// Answer handshake properties; bound into mem_emu_top and counts its own assertion failures
`timescale 1ns/10ps

module mem_emu_checker (
    input logic                     clk_i,
    input logic                     arst_n_i,
    input logic                     flush_i,
    input logic                     ready_i,
    input logic                     ans_valid_i,
    input logic                     req_ready_i,
    input mem_pkg::tag_t            ans_tag_i,
    input mem_pkg::acc_type_t       ans_acc_type_i,
    input mem_pkg::addr_t           ans_addr_i,
    input mem_pkg::data_t           ans_value_i,
    input logic                     ans_except_i,
    input except_pkg::except_code_t ans_code_i
);

    int assert_errs = 0;

    // Buffer empty and open while in reset and on the first edge after it
    reset_state: assert property (@(posedge clk_i)
        (!arst_n_i || $rose(arst_n_i)) |-> (!ans_valid_i && req_ready_i))
        else begin
            $error("valid_o/ready_o not in reset state");
            assert_errs++;
        end

    // Held answer must not move under back-pressure
    hold_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (ans_valid_i && !ready_i && !flush_i) |=>
        (ans_valid_i && $stable(ans_tag_i) && $stable(ans_acc_type_i) &&
         $stable(ans_addr_i) && $stable(ans_value_i) && $stable(ans_except_i) &&
         $stable(ans_code_i)))
        else begin
            $error("answer changed while stalled");
            assert_errs++;
        end

    flush_empties: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        flush_i |=> !ans_valid_i)
        else begin
            $error("valid_o high after flush");
            assert_errs++;
        end

    empty_is_ready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !ans_valid_i |-> req_ready_i)
        else begin
            $error("ready_o low with empty buffer");
            assert_errs++;
        end

endmodule

// ==== tests/mem_emu_tb.sv ====
// Array is fully written before any read; the reference model tracks bytes and pending answers
`timescale 1ns/10ps

module mem_emu_tb;

    localparam int TIMEOUT = 200;

    logic clk_i;
    logic arst_n_i;
    logic flush_i;
    logic valid_i;
    logic ready_i;
    mem_pkg::tag_t            req_tag_i;
    mem_pkg::acc_type_t       req_acc_type_i;
    mem_pkg::ls_type_t        req_ls_type_i;
    mem_pkg::addr_t           req_addr_i;
    mem_pkg::data_t           req_value_i;
    logic                     ready_o;
    logic                     valid_o;
    mem_pkg::tag_t            ans_tag_o;
    mem_pkg::acc_type_t       ans_acc_type_o;
    mem_pkg::addr_t           ans_addr_o;
    mem_pkg::data_t           ans_value_o;
    logic                     ans_except_o;
    except_pkg::except_code_t ans_except_code_o;

    logic [7:0]               model_mem [mem_pkg::MEM_BYTES];
    mem_pkg::tag_t            exp_tag [$];
    mem_pkg::acc_type_t       exp_acc [$];
    mem_pkg::addr_t           exp_addr [$];
    mem_pkg::data_t           exp_val [$];
    except_pkg::except_code_t exp_code [$];
    mem_pkg::tag_t            next_tag;
    int                       val_errs;
    int                       proto_errs;
    int                       low_left;
    logic                     bp_on;
    logic                     stall;

    mem_emu_top mem_emu_inst (.*);

    bind mem_emu_top mem_emu_checker checker_inst (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .flush_i        (flush_i),
        .ready_i        (ready_i),
        .ans_valid_i    (valid_o),
        .req_ready_i    (ready_o),
        .ans_tag_i      (ans_tag_o),
        .ans_acc_type_i (ans_acc_type_o),
        .ans_addr_i     (ans_addr_o),
        .ans_value_i    (ans_value_o),
        .ans_except_i   (ans_except_o),
        .ans_code_i     (ans_except_code_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic void apply_request(input mem_pkg::acc_type_t acc,
            input mem_pkg::ls_type_t ls, input mem_pkg::addr_t addr,
            input mem_pkg::data_t wdata, output mem_pkg::data_t val,
            output except_pkg::except_code_t code);
        int   nbytes;
        logic sign;
        nbytes = 8;
        if (acc == mem_pkg::ACC_INSTR || ls inside {mem_pkg::LS_WORD, mem_pkg::LS_WORD_U})
            nbytes = 4;
        else if (ls inside {mem_pkg::LS_HALF, mem_pkg::LS_HALF_U})
            nbytes = 2;
        else if (ls inside {mem_pkg::LS_BYTE, mem_pkg::LS_BYTE_U})
            nbytes = 1;
        val  = '0;
        code = except_pkg::E_UNKNOWN;
        if ((addr % mem_pkg::addr_t'(nbytes)) != '0) begin
            code = (acc == mem_pkg::ACC_INSTR) ? except_pkg::E_I_ADDR_MISALIGNED :
                   (acc == mem_pkg::ACC_LD)    ? except_pkg::E_LD_ADDR_MISALIGNED :
                                                 except_pkg::E_ST_ADDR_MISALIGNED;
        end else if (longint'(addr) + longint'(nbytes) > longint'(mem_pkg::MEM_BYTES)) begin
            code = (acc == mem_pkg::ACC_INSTR) ? except_pkg::E_I_ACCESS_FAULT :
                   (acc == mem_pkg::ACC_LD)    ? except_pkg::E_LD_ACCESS_FAULT :
                                                 except_pkg::E_ST_ACCESS_FAULT;
        end else if (acc == mem_pkg::ACC_ST) begin
            for (int b = 0; b < nbytes; b++)
                model_mem[mem_pkg::idx_t'(addr + mem_pkg::addr_t'(b))] = wdata[8*b +: 8];
        end else begin
            // Signed loads only; fetches and unsigned loads fill with zero
            sign = (acc == mem_pkg::ACC_LD) &&
                   (ls inside {mem_pkg::LS_BYTE, mem_pkg::LS_HALF, mem_pkg::LS_WORD}) &&
                   model_mem[mem_pkg::idx_t'(addr + mem_pkg::addr_t'(nbytes - 1))][7];
            for (int b = 0; b < 8; b++)
                val[8*b +: 8] = (b < nbytes) ?
                    model_mem[mem_pkg::idx_t'(addr + mem_pkg::addr_t'(b))] : {8{sign}};
        end
    endfunction

    task automatic check_tag(input string name, input mem_pkg::tag_t got,
            input mem_pkg::tag_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            val_errs++;
        end
    endtask

    task automatic check_acc_type(input string name, input mem_pkg::acc_type_t got,
            input mem_pkg::acc_type_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            val_errs++;
        end
    endtask

    task automatic check_addr(input string name, input mem_pkg::addr_t got,
            input mem_pkg::addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            val_errs++;
        end
    endtask

    task automatic check_value(input string name, input mem_pkg::data_t got,
            input mem_pkg::data_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            val_errs++;
        end
    endtask

    task automatic check_except(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            val_errs++;
        end
    endtask

    task automatic check_code(input string name, input except_pkg::except_code_t got,
            input except_pkg::except_code_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
            val_errs++;
        end
    endtask

    // Takes first, then acceptance, then flush, all on pre-edge values
    always @(posedge clk_i) begin : monitor
        mem_pkg::data_t           val;
        except_pkg::except_code_t code;
        except_pkg::except_code_t want_code;
        if (arst_n_i) begin
            if (ready_o != (exp_tag.size() < 2) || valid_o != (exp_tag.size() != 0)) begin
                $display("Handshake does not match %0d pending answers", exp_tag.size());
                proto_errs++;
            end
            if (valid_o && ready_i) begin
                if (exp_tag.size() == 0) begin
                    $display("Answer delivered with no request pending");
                    proto_errs++;
                end else begin
                    want_code = exp_code.pop_front();
                    check_tag("ans_tag_o", ans_tag_o, exp_tag.pop_front());
                    check_acc_type("ans_acc_type_o", ans_acc_type_o, exp_acc.pop_front());
                    check_addr("ans_addr_o", ans_addr_o, exp_addr.pop_front());
                    check_code("ans_except_code_o", ans_except_code_o, want_code);
                    check_except("ans_except_o", ans_except_o,
                                 want_code != except_pkg::E_UNKNOWN);
                    check_value("ans_value_o", ans_value_o, exp_val.pop_front());
                end
            end
            if (valid_i && ready_o) begin
                apply_request(req_acc_type_i, req_ls_type_i, req_addr_i, req_value_i,
                              val, code);
                exp_tag.push_back(req_tag_i);
                exp_acc.push_back(req_acc_type_i);
                exp_addr.push_back(req_addr_i);
                exp_val.push_back(val);
                exp_code.push_back(code);
            end
            if (flush_i) begin
                exp_tag.delete();
                exp_acc.delete();
                exp_addr.delete();
                exp_val.delete();
                exp_code.delete();
            end
        end
    end

    // Random low stretches on ready_i
    always @(posedge clk_i) begin
        if (stall) begin
            ready_i <= 1'b0;
        end else if (!bp_on) begin
            ready_i <= 1'b1;
        end else if (low_left > 0) begin
            ready_i <= 1'b0;
            low_left = low_left - 1;
        end else if ($urandom_range(0, 3) == 0) begin
            ready_i <= 1'b0;
            low_left = $urandom_range(0, 4);
        end else begin
            ready_i <= 1'b1;
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    task automatic drive_req(input mem_pkg::acc_type_t acc, input mem_pkg::ls_type_t ls,
            input mem_pkg::addr_t addr, input mem_pkg::data_t value);
        valid_i        <= 1'b1;
        req_tag_i      <= next_tag;
        req_acc_type_i <= acc;
        req_ls_type_i  <= ls;
        req_addr_i     <= addr;
        req_value_i    <= value;
        next_tag = next_tag + 1'b1;
    endtask

    // Mostly aligned in range, some misaligned, some past the end
    task automatic drive_random();
        int             pick;
        mem_pkg::addr_t addr;
        pick = $urandom_range(0, 9);
        addr = mem_pkg::addr_t'($urandom_range(0, mem_pkg::MEM_BYTES - 1));
        if (pick < 6)
            addr[2:0] = 3'd0;
        else if (pick == 8)
            addr = mem_pkg::addr_t'(mem_pkg::MEM_BYTES - 8 + $urandom_range(0, 15));
        else if (pick == 9)
            addr = $urandom();
        drive_req(mem_pkg::acc_type_t'($urandom_range(0, 2)),
                  mem_pkg::ls_type_t'($urandom_range(0, 6)), addr, {$urandom(), $urandom()});
    endtask

    task automatic wait_accept();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk_i);
            cycles++;
        end while (!ready_o && cycles < TIMEOUT);
        valid_i <= 1'b0;
        if (!ready_o) begin
            $display("Timeout: request was never accepted");
            $display("RESULT: FAIL");
            $finish;
        end
    endtask

    // Sampled between edges so the model queue is settled
    task automatic drain_answers();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
        end while (exp_tag.size() != 0 && cycles < TIMEOUT);
        if (exp_tag.size() != 0) begin
            $display("Answers still pending after drain timeout");
            proto_errs++;
        end
    endtask

    task automatic run_random(input int count);
        repeat (count) begin
            drive_random();
            wait_accept();
            repeat ($urandom_range(0, 2)) @(posedge clk_i);
        end
    endtask

    initial begin : stimulus
        void'($urandom(32'ha5fbe051));
        arst_n_i       = 1'b0;
        flush_i        = 1'b0;
        valid_i        = 1'b0;
        ready_i        = 1'b1;
        req_tag_i      = '0;
        req_acc_type_i = mem_pkg::ACC_LD;
        req_ls_type_i  = mem_pkg::LS_DWORD;
        req_addr_i     = '0;
        req_value_i    = '0;
        next_tag       = '0;
        val_errs       = 0;
        proto_errs     = 0;
        low_left       = 0;
        bp_on          = 1'b0;
        stall          = 1'b0;
        repeat (3) @(posedge clk_i);
        arst_n_i <= 1'b1;

        for (int i = 0; i < mem_pkg::MEM_BYTES / 8; i++) begin
            drive_req(mem_pkg::ACC_ST, mem_pkg::LS_DWORD, mem_pkg::addr_t'(8 * i),
                      {$urandom(), $urandom()});
            wait_accept();
        end
        run_random(100);
        bp_on = 1'b1;
        run_random(150);
        bp_on = 1'b0;
        drain_answers();

        // One flush with a held answer and a request in the same cycle
        stall = 1'b1;
        @(posedge clk_i);
        drive_random();
        wait_accept();
        drive_random();
        flush_i <= 1'b1;
        @(posedge clk_i);
        valid_i <= 1'b0;
        flush_i <= 1'b0;
        @(negedge clk_i);
        stall = 1'b0;
        bp_on = 1'b1;
        @(posedge clk_i);
        run_random(100);

        bp_on = 1'b0;
        drain_answers();
        $display("Errors: value %0d, protocol %0d, assertion %0d", val_errs, proto_errs,
                 mem_emu_inst.checker_inst.assert_errs);
        if (val_errs + proto_errs + mem_emu_inst.checker_inst.assert_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== mem_emu.f ====
source/mem_pkg.sv
source/except_pkg.sv
source/mem_req_check.sv
source/mem_byte_array.sv
source/mem_ans_buffer.sv
source/mem_emu_top.sv
tests/mem_emu_checker.sv
tests/mem_emu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     := --timing --assert
SIMFLAGS  := +verilator+error+limit+1000
TOP       := mem_emu_tb
FILELIST  := mem_emu.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(SIMFLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
